// ==== logic/axis_out_macros.svh ====
`ifndef AXIS_OUT_MACROS_SVH
`define AXIS_OUT_MACROS_SVH

// FIFO depth in words, as a power of two
`define AXIS_OUT_FIFO_DEPTH_LOG2 3
`define AXIS_OUT_FIFO_DEPTH      (1 << `AXIS_OUT_FIFO_DEPTH_LOG2)

// Stream geometry, four byte lanes per CPU word
`define AXIS_OUT_LANES  4
`define AXIS_OUT_LANE_W 8
`define AXIS_OUT_WORD_W (`AXIS_OUT_LANES * `AXIS_OUT_LANE_W)

// Register map, word offsets on the Wishbone port
`define AXIS_OUT_ADDR_W         2
`define AXIS_OUT_ADDR_DATA      2'd0
`define AXIS_OUT_ADDR_LAST_MASK 2'd1
`define AXIS_OUT_ADDR_STATUS    2'd2

`endif

// ==== logic/axis_out_regs_pkg.sv ====
`include "axis_out_macros.svh"

package axis_out_regs_pkg;

   // Register offsets as seen by software
   typedef enum logic [`AXIS_OUT_ADDR_W-1:0] {
      REG_DATA      = `AXIS_OUT_ADDR_DATA,
      REG_LAST_MASK = `AXIS_OUT_ADDR_LAST_MASK,
      REG_STATUS    = `AXIS_OUT_ADDR_STATUS
   } reg_idx_e;

   // Words in flight, FIFO plus the one held by the serializer
   typedef logic [`AXIS_OUT_FIFO_DEPTH_LOG2:0] count_t;

   // Status word layout
   // In-flight count sits in the low nibble
   localparam int STAT_COUNT_LSB = 0;
   localparam int STAT_COUNT_W = $bits(count_t);

   // FIFO holds its full depth
   localparam int STAT_FULL_BIT = 8;

   // Last mask written and its word not yet sent out
   localparam int STAT_LAST_PEND_BIT = 9;

endpackage

// ==== logic/axis_out_stream_pkg.sv ====
`include "axis_out_macros.svh"

package axis_out_stream_pkg;

   // One valid bit per stream lane
   typedef logic [`AXIS_OUT_LANES-1:0] lane_mask_t;

   // CPU word, written whole, read back lane by lane
   // Lane 0 is the low byte and goes out first
   typedef union packed {
      logic [`AXIS_OUT_WORD_W-1:0] word;
      logic [`AXIS_OUT_LANES-1:0][`AXIS_OUT_LANE_W-1:0] lane;
   } lane_word_u;

endpackage

// ==== logic/axis_out_word_if.sv ====
`timescale 1ns/1ps

interface axis_out_word_if;

   // Handshake
   logic valid;
   logic ready;

   // Payload, held stable while valid waits for ready
   axis_out_stream_pkg::lane_word_u data;
   axis_out_stream_pkg::lane_mask_t mask;
   logic last;

   // Producer side
   modport source (
      output valid,
      output data,
      output mask,
      output last,
      input  ready
   );

   // Consumer side
   modport sink (
      input  valid,
      input  data,
      input  mask,
      input  last,
      output ready
   );

endinterface

// ==== logic/axis_out_wb_regs.sv ====
`timescale 1ns/1ps
`include "axis_out_macros.svh"

module axis_out_wb_regs (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          wb_cyc,
   input  logic                          wb_stb,
   input  logic                          wb_we,
   input  logic [`AXIS_OUT_ADDR_W-1:0]   wb_adr,
   input  logic [`AXIS_OUT_WORD_W-1:0]   wb_dat_w,
   output logic [`AXIS_OUT_WORD_W-1:0]   wb_dat_r,
   output logic                          wb_ack,
   axis_out_word_if.source               push,
   input  logic                          word_done
);

   axis_out_regs_pkg::reg_idx_e     reg_idx;
   axis_out_regs_pkg::count_t       count;
   axis_out_regs_pkg::count_t       count_nxt;
   axis_out_regs_pkg::count_t       last_left;
   axis_out_stream_pkg::lane_mask_t mask_q;
   logic                            mask_armed;
   logic                            last_pending;
   logic                            fifo_full;
   logic                            req;
   logic                            start;
   logic                            data_wr;
   logic                            mask_wr;
   logic                            push_fire;
   logic [`AXIS_OUT_WORD_W-1:0]     status;
   logic [`AXIS_OUT_WORD_W-1:0]     rd_word;

   assign req     = wb_cyc & wb_stb;
   assign reg_idx = axis_out_regs_pkg::reg_idx_e'(wb_adr);

   // Take a new access only when no ack and no push is in progress
   assign start   = req & ~wb_ack & ~push.valid;
   assign data_wr = wb_we & (reg_idx == axis_out_regs_pkg::REG_DATA);
   assign mask_wr = wb_we & (reg_idx == axis_out_regs_pkg::REG_LAST_MASK);

   assign push_fire = push.valid & push.ready;
   assign fifo_full = ~push.ready;

   // Push and completion may land on the same edge
   assign count_nxt = count + axis_out_regs_pkg::count_t'(push_fire)
                            - axis_out_regs_pkg::count_t'(word_done);

   // Pending until the most recent last word has fully left
   assign last_pending = mask_armed | (last_left != '0);

   // Ack and push handshake
   // A DATA write holds off its ack until the FIFO takes the word
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wb_ack     <= 1'b0;
         push.valid <= 1'b0;
      end else begin
         wb_ack <= 1'b0;
         if (push_fire) begin
            push.valid <= 1'b0;
            wb_ack     <= 1'b1;
         end else if (start && data_wr) begin
            push.valid <= 1'b1;
         end else if (start) begin
            wb_ack <= 1'b1;
         end
      end
   end

   // Word payload, mask and last come from the armed last mask
   always_ff @(posedge clk) begin
      if (start && data_wr) begin
         push.data.word <= wb_dat_w;
         push.mask      <= mask_armed ? mask_q : '1;
         push.last      <= mask_armed;
      end
   end

   // Last mask register
   // Zero disarms, nonzero arms the next DATA word as the final one
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         mask_q     <= '0;
         mask_armed <= 1'b0;
      end else if (start && mask_wr) begin
         mask_q     <= wb_dat_w[`AXIS_OUT_LANES-1:0];
         mask_armed <= |wb_dat_w[`AXIS_OUT_LANES-1:0];
      end else if (push_fire && push.last) begin
         mask_armed <= 1'b0;
      end
   end

   // In-flight count, and words left until the last-marked one is done
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         count     <= '0;
         last_left <= '0;
      end else begin
         count <= count_nxt;
         if (push_fire && push.last) begin
            last_left <= count_nxt;
         end else if (word_done && last_left != '0) begin
            last_left <= last_left - 1'b1;
         end
      end
   end

   always_comb begin
      status = '0;
      status[axis_out_regs_pkg::STAT_COUNT_LSB +: axis_out_regs_pkg::STAT_COUNT_W] = count;
      status[axis_out_regs_pkg::STAT_FULL_BIT]      = fifo_full;
      status[axis_out_regs_pkg::STAT_LAST_PEND_BIT] = last_pending;
   end

   // Read mux, DATA reads back as zero
   always_comb begin
      rd_word = '0;
      case (reg_idx)
         axis_out_regs_pkg::REG_STATUS: rd_word = status;
         axis_out_regs_pkg::REG_LAST_MASK: begin
            if (mask_armed) begin
               rd_word[`AXIS_OUT_LANES-1:0] = mask_q;
            end
         end
         default: rd_word = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (start && !wb_we) begin
         wb_dat_r <= rd_word;
      end
   end

   // Ack only answers a live cycle from the master
   a_ack_in_cycle: assert property (
      @(posedge clk) disable iff (!rst_n) wb_ack |-> (wb_cyc && wb_stb)
   );

endmodule

// ==== logic/axis_out_word_fifo.sv ====
`timescale 1ns/1ps
`include "axis_out_macros.svh"

module axis_out_word_fifo (
   input  logic          clk,
   input  logic          rst_n,
   axis_out_word_if.sink   push,
   axis_out_word_if.source pop
);

   // Storage array, no reset on payload
   axis_out_stream_pkg::lane_word_u mem_data [`AXIS_OUT_FIFO_DEPTH];
   axis_out_stream_pkg::lane_mask_t mem_mask [`AXIS_OUT_FIFO_DEPTH];
   logic                            mem_last [`AXIS_OUT_FIFO_DEPTH];

   logic [`AXIS_OUT_FIFO_DEPTH_LOG2-1:0] wr_ptr;
   logic [`AXIS_OUT_FIFO_DEPTH_LOG2-1:0] rd_ptr;
   logic [`AXIS_OUT_FIFO_DEPTH_LOG2-1:0] mem_used;
   // Words held, array plus output stage
   logic [`AXIS_OUT_FIFO_DEPTH_LOG2:0]   level;
   logic                                 push_fire;
   logic                                 pop_fire;
   logic                                 load_out;
   logic                                 mem_empty;
   logic                                 mem_rd;
   logic                                 mem_wr;
   logic                                 bypass;

   assign push_fire = push.valid & push.ready;
   assign pop_fire  = pop.valid & pop.ready;
   assign push.ready = (level != `AXIS_OUT_FIFO_DEPTH);

   // Output stage is free this edge
   assign load_out  = ~pop.valid | pop_fire;
   assign mem_empty = (wr_ptr == rd_ptr);
   assign mem_used  = wr_ptr - rd_ptr;
   assign mem_rd    = load_out & ~mem_empty;

   // Empty array, incoming word goes straight to the output stage
   assign bypass = load_out & mem_empty & push_fire;
   assign mem_wr = push_fire & ~bypass;

   always_ff @(posedge clk) begin
      if (mem_wr) begin
         mem_data[wr_ptr] <= push.data;
         mem_mask[wr_ptr] <= push.mask;
         mem_last[wr_ptr] <= push.last;
      end
   end

   // Pointers and occupancy
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         level  <= '0;
      end else begin
         if (mem_wr) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (mem_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         level <= level + push_fire - pop_fire;
      end
   end

   // Registered output, presented as soon as it holds a word
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pop.valid <= 1'b0;
      end else if (load_out) begin
         pop.valid <= mem_rd | bypass;
      end
   end

   always_ff @(posedge clk) begin
      if (mem_rd) begin
         pop.data <= mem_data[rd_ptr];
         pop.mask <= mem_mask[rd_ptr];
         pop.last <= mem_last[rd_ptr];
      end else if (bypass) begin
         pop.data <= push.data;
         pop.mask <= push.mask;
         pop.last <= push.last;
      end
   end

   // Occupancy stays within depth and matches pointers plus output stage
   a_level_match: assert property (
      @(posedge clk) disable iff (!rst_n)
      (level <= `AXIS_OUT_FIFO_DEPTH) && (level == mem_used + pop.valid)
   );

   // Stalled output keeps its word
   a_pop_stable: assert property (
      @(posedge clk) disable iff (!rst_n)
      (pop.valid && !pop.ready) |=>
         (pop.valid && $stable(pop.data) && $stable(pop.mask) && $stable(pop.last))
   );

endmodule

// ==== logic/axis_out_serializer.sv ====
`timescale 1ns/1ps
`include "axis_out_macros.svh"

module axis_out_serializer (
   input  logic                         clk,
   input  logic                         rst_n,
   axis_out_word_if.sink                word,
   output logic [`AXIS_OUT_LANE_W-1:0]  m_tdata,
   output logic                         m_tvalid,
   output logic                         m_tlast,
   input  logic                         m_tready,
   output logic                         word_done
);

   // Word being sent and the lanes still to go
   axis_out_stream_pkg::lane_word_u word_q;
   axis_out_stream_pkg::lane_mask_t rem_mask;
   axis_out_stream_pkg::lane_mask_t low_bit;
   axis_out_stream_pkg::lane_mask_t rem_after;
   logic                            last_q;
   logic                            beat_fire;
   logic                            final_beat;
   logic                            take;

   // Lowest set lane is the current beat
   assign low_bit   = rem_mask & axis_out_stream_pkg::lane_mask_t'(~rem_mask + 1'b1);
   assign rem_after = rem_mask & ~low_bit;

   assign beat_fire  = m_tvalid & m_tready;
   assign final_beat = beat_fire & (rem_after == '0);

   // Next word is taken on the final beat, no bubble between words
   assign word.ready = ~m_tvalid | final_beat;
   assign take       = word.valid & word.ready;

   // Completion strobe for the in-flight count
   assign word_done = final_beat;

   // TLAST on the only lane left of a last-marked word
   assign m_tlast = last_q & (rem_mask != '0) & (rem_after == '0);

   // Lane select through the lane view of the word
   always_comb begin
      m_tdata = '0;
      for (int i = 0; i < `AXIS_OUT_LANES; i++) begin
         if (low_bit[i]) begin
            m_tdata = word_q.lane[i];
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         m_tvalid <= 1'b0;
         rem_mask <= '0;
         last_q   <= 1'b0;
      end else if (take) begin
         m_tvalid <= 1'b1;
         rem_mask <= word.mask;
         last_q   <= word.last;
      end else if (beat_fire) begin
         // Drop the lane just accepted
         rem_mask <= rem_after;
         if (final_beat) begin
            m_tvalid <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (take) begin
         word_q <= word.data;
      end
   end

   // Mask runs empty together with valid
   a_tlast_valid: assert property (
      @(posedge clk) disable iff (!rst_n) m_tlast |-> m_tvalid
   );

endmodule

// ==== logic/axis_out_top.sv ====
`timescale 1ns/1ps
`include "axis_out_macros.svh"

module axis_out_top (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic                         wb_cyc,
   input  logic                         wb_stb,
   input  logic                         wb_we,
   input  logic [`AXIS_OUT_ADDR_W-1:0]  wb_adr,
   input  logic [`AXIS_OUT_WORD_W-1:0]  wb_dat_w,
   output logic [`AXIS_OUT_WORD_W-1:0]  wb_dat_r,
   output logic                         wb_ack,
   output logic [`AXIS_OUT_LANE_W-1:0]  m_tdata,
   output logic                         m_tvalid,
   output logic                         m_tlast,
   input  logic                         m_tready
);

   // Completion pulse back to the register block
   logic word_done;

   // Registers to FIFO, FIFO to serializer
   axis_out_word_if push_if ();
   axis_out_word_if pop_if ();

   axis_out_wb_regs i_regs (
      .clk       (clk),
      .rst_n     (rst_n),
      .wb_cyc    (wb_cyc),
      .wb_stb    (wb_stb),
      .wb_we     (wb_we),
      .wb_adr    (wb_adr),
      .wb_dat_w  (wb_dat_w),
      .wb_dat_r  (wb_dat_r),
      .wb_ack    (wb_ack),
      .push      (push_if.source),
      .word_done (word_done)
   );

   axis_out_word_fifo i_fifo (
      .clk   (clk),
      .rst_n (rst_n),
      .push  (push_if.sink),
      .pop   (pop_if.source)
   );

   axis_out_serializer i_ser (
      .clk       (clk),
      .rst_n     (rst_n),
      .word      (pop_if.sink),
      .m_tdata   (m_tdata),
      .m_tvalid  (m_tvalid),
      .m_tlast   (m_tlast),
      .m_tready  (m_tready),
      .word_done (word_done)
   );

endmodule

// ==== sim/axis_out_checker.sv ====
`timescale 1ns/1ps
`include "axis_out_macros.svh"

module axis_out_checker (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        wb_cyc,
   input  logic                        wb_stb,
   input  logic                        wb_we,
   input  logic [`AXIS_OUT_ADDR_W-1:0] wb_adr,
   input  logic [`AXIS_OUT_WORD_W-1:0] wb_dat_w,
   input  logic [`AXIS_OUT_WORD_W-1:0] wb_dat_r,
   input  logic                        wb_ack,
   input  logic [`AXIS_OUT_LANE_W-1:0] m_tdata,
   input  logic                        m_tvalid,
   input  logic                        m_tlast,
   input  logic                        m_tready,
   output int                          exp_left,
   output int                          value_errors,
   output int                          flow_errors
);

   // One expected beat, word_end on the last lane sent of its word
   typedef struct packed {
      logic                        word_end;
      logic                        last;
      logic [`AXIS_OUT_LANE_W-1:0] data;
   } beat_t;

   beat_t                      exp_q[$];
   beat_t                      beat;
   logic [`AXIS_OUT_LANES-1:0] last_mask;
   logic                       mask_armed;
   logic                       data_req;
   // Words written and not fully sent, and the last-marked ones among them
   int                         in_flight;
   int                         lasts_open;
   // Request edges and full-FIFO edges of the DATA write in progress
   int                         wr_edges;
   int                         wr_stalls;

   assign data_req = wb_cyc && wb_stb && wb_we && (wb_adr == `AXIS_OUT_ADDR_DATA);

   task automatic report_mismatch(input string msg);
      value_errors++;
      $display("[FAIL] %0t ns: %s", $time, msg);
   endtask

   // One word sits in the serializer, the rest wait in the FIFO
   function automatic int fifo_words();
      return (in_flight > 0) ? in_flight - 1 : 0;
   endfunction

   function automatic logic [`AXIS_OUT_WORD_W-1:0] model_status();
      logic [`AXIS_OUT_WORD_W-1:0] s;
      s = '0;
      s[axis_out_regs_pkg::STAT_COUNT_LSB +: axis_out_regs_pkg::STAT_COUNT_W] = in_flight;
      s[axis_out_regs_pkg::STAT_FULL_BIT] = (fifo_words() == `AXIS_OUT_FIFO_DEPTH);
      s[axis_out_regs_pkg::STAT_LAST_PEND_BIT] = mask_armed || (lasts_open > 0);
      return s;
   endfunction

   // Set lanes in rising order, TLAST on the top one of a last word
   task automatic expect_word(input logic [`AXIS_OUT_WORD_W-1:0] w);
      logic [`AXIS_OUT_LANES-1:0] mask;
      int top;
      mask = mask_armed ? last_mask : '1;
      top = 0;
      for (int i = 0; i < `AXIS_OUT_LANES; i++) begin
         if (mask[i]) begin
            top = i;
         end
      end
      for (int i = 0; i < `AXIS_OUT_LANES; i++) begin
         if (mask[i]) begin
            exp_q.push_back({i == top, mask_armed && (i == top),
                             w[i*`AXIS_OUT_LANE_W +: `AXIS_OUT_LANE_W]});
         end
      end
      if (mask_armed) begin
         lasts_open++;
      end
      mask_armed = 1'b0;
      in_flight++;
   endtask

   always @(posedge clk) begin
      if (!rst_n) begin
         if (m_tvalid || m_tlast || wb_ack) begin
            flow_errors++;
            $display("Outputs active during reset at %0t ns", $time);
         end
         exp_q.delete();
         mask_armed = 1'b0;
         last_mask  = '0;
         in_flight  = 0;
         lasts_open = 0;
         wr_edges   = 0;
         wr_stalls  = 0;
      end else begin
         // DATA write timing, FIFO room as it was before this edge
         if (data_req && !wb_ack) begin
            if (wr_edges > 0 && fifo_words() == `AXIS_OUT_FIFO_DEPTH) begin
               wr_stalls++;
            end
            wr_edges++;
         end
         if (m_tvalid && exp_q.size() == 0) begin
            flow_errors++;
            $display("m_tvalid high at %0t ns with no data written for it", $time);
         end else if (m_tvalid && m_tready) begin
            beat = exp_q.pop_front();
            if (m_tdata !== beat.data) begin
               report_mismatch($sformatf("m_tdata 0x%02h, expected 0x%02h", m_tdata, beat.data));
            end
            if (m_tlast !== beat.last) begin
               report_mismatch($sformatf("m_tlast %b, expected %b", m_tlast, beat.last));
            end
            in_flight  -= beat.word_end;
            lasts_open -= beat.last;
         end
         // Completed bus accesses
         if (wb_cyc && wb_stb && wb_ack) begin
            if (data_req) begin
               if (wr_edges + 1 != 3 + wr_stalls) begin
                  report_mismatch($sformatf("DATA write took %0d cycles, expected %0d",
                                            wr_edges + 1, 3 + wr_stalls));
               end
               wr_edges  = 0;
               wr_stalls = 0;
               expect_word(wb_dat_w);
            end else if (wb_we && wb_adr == `AXIS_OUT_ADDR_LAST_MASK) begin
               last_mask  = wb_dat_w[`AXIS_OUT_LANES-1:0];
               mask_armed = |wb_dat_w[`AXIS_OUT_LANES-1:0];
            end else if (!wb_we && wb_adr == `AXIS_OUT_ADDR_STATUS) begin
               if (wb_dat_r !== model_status()) begin
                  report_mismatch($sformatf("STATUS 0x%08h, expected 0x%08h",
                                            wb_dat_r, model_status()));
               end
            end
         end
      end
      exp_left <= exp_q.size();
   end

endmodule

// ==== sim/tb_axis_out.sv ====
`timescale 1ns/1ps
`include "axis_out_macros.svh"

module tb_axis_out;

   localparam int          CLK_HALF  = 4;
   localparam logic [31:0] SEED      = 32'hc14d_7099;
   localparam int          N_PACKETS = 40;
   // Worst case 6 words of 4 beats per packet at 4 cycles a beat plus margin
   localparam int WATCHDOG_CYCLES = N_PACKETS * 6 * `AXIS_OUT_LANES * 4 + 2000;
   // Drain bound for a full FIFO and serializer plus one word at 4 cycles a beat
   localparam int DRAIN_CYCLES = (`AXIS_OUT_FIFO_DEPTH + 2) * `AXIS_OUT_LANES * 4;
   // Stream ready modes
   localparam int RDY_LOW    = 0;
   localparam int RDY_RANDOM = 1;
   localparam int RDY_HIGH   = 2;

   logic                        clk;
   logic                        rst_n;
   logic                        wb_cyc;
   logic                        wb_stb;
   logic                        wb_we;
   logic [`AXIS_OUT_ADDR_W-1:0] wb_adr;
   logic [`AXIS_OUT_WORD_W-1:0] wb_dat_w;
   logic [`AXIS_OUT_WORD_W-1:0] wb_dat_r;
   logic                        wb_ack;
   logic [`AXIS_OUT_LANE_W-1:0] m_tdata;
   logic                        m_tvalid;
   logic                        m_tlast;
   logic                        m_tready;
   logic [31:0]                 stim_state;
   logic [31:0]                 rdy_state;
   logic                        tenth_acked;
   int                          rdy_mode;
   int                          exp_left;
   int                          value_errors;
   int                          flow_errors;
   int                          seq_errors;

   axis_out_top i_dut (.*);

   axis_out_checker i_chk (.*);

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s ^ (s << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] stim_rand();
      stim_state = xorshift32(stim_state);
      return stim_state;
   endfunction

   initial begin
      clk = 1'b0;
      forever begin
         #CLK_HALF clk = ~clk;
      end
   end

   // Ready draws from its own random stream
   always @(posedge clk) begin
      if (rdy_mode == RDY_RANDOM) begin
         rdy_state = xorshift32(rdy_state);
         m_tready <= (rdy_state % 100) < 70;
      end else begin
         m_tready <= (rdy_mode == RDY_HIGH);
      end
   end

   // Classic cycle held until ack and followed by one idle cycle
   task automatic wb_access(input logic we, input logic [`AXIS_OUT_ADDR_W-1:0] adr,
                            input logic [`AXIS_OUT_WORD_W-1:0] dat);
      @(posedge clk);
      wb_cyc   <= 1'b1;
      wb_stb   <= 1'b1;
      wb_we    <= we;
      wb_adr   <= adr;
      wb_dat_w <= dat;
      do begin
         @(posedge clk);
      end while (!wb_ack);
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
   endtask

   // Packet of 1 to 6 words with mask 1, 3, 7 or F written before the final word
   task automatic send_packet();
      logic [31:0] r;
      int          n_words;
      r = stim_rand();
      n_words = 1 + (r % 6);
      for (int i = 0; i < n_words; i++) begin
         if (i == n_words - 1) begin
            wb_access(1'b1, `AXIS_OUT_ADDR_LAST_MASK, (1 << (1 + r[9:8])) - 1);
         end
         wb_access(1'b1, `AXIS_OUT_ADDR_DATA, stim_rand());
      end
   endtask

   // Bounded wait for the expected beat queue to empty
   task automatic wait_drained();
      int n;
      n = 0;
      @(posedge clk);
      while (exp_left != 0 && n < DRAIN_CYCLES) begin
         @(posedge clk);
         n++;
      end
   endtask

   initial begin
      rst_n       = 1'b0;
      wb_cyc      = 1'b0;
      wb_stb      = 1'b0;
      wb_we       = 1'b0;
      wb_adr      = '0;
      wb_dat_w    = '0;
      m_tready    = 1'b0;
      rdy_mode    = RDY_LOW;
      stim_state  = SEED;
      rdy_state   = SEED ^ 32'h9e37_79b9;
      tenth_acked = 1'b0;
      seq_errors  = 0;
      repeat (2) @(posedge clk);
      rst_n <= 1'b1;
      // Idle status with the stream held off
      repeat (2) @(posedge clk);
      wb_access(1'b0, `AXIS_OUT_ADDR_STATUS, '0);
      rdy_mode <= RDY_RANDOM;
      for (int p = 0; p < N_PACKETS; p++) begin
         send_packet();
      end
      wait_drained();
      // Stall the stream and arm a last mask before filling FIFO and serializer
      rdy_mode <= RDY_LOW;
      repeat (2) @(posedge clk);
      wb_access(1'b1, `AXIS_OUT_ADDR_LAST_MASK, 32'h7);
      wb_access(1'b0, `AXIS_OUT_ADDR_STATUS, '0);
      for (int i = 0; i < `AXIS_OUT_FIFO_DEPTH + 1; i++) begin
         wb_access(1'b1, `AXIS_OUT_ADDR_DATA, stim_rand());
      end
      wb_access(1'b0, `AXIS_OUT_ADDR_STATUS, '0);
      // Tenth word must wait for the stream
      fork
         begin
            wb_access(1'b1, `AXIS_OUT_ADDR_DATA, stim_rand());
            tenth_acked = 1'b1;
         end
         begin
            repeat (16) @(posedge clk);
            if (tenth_acked) begin
               seq_errors++;
               $display("DATA write acknowledged while the FIFO was full and the stream stalled");
            end
            rdy_mode <= RDY_HIGH;
         end
      join
      wait_drained();
      rdy_mode <= RDY_LOW;
      repeat (2) @(posedge clk);
      wb_access(1'b0, `AXIS_OUT_ADDR_STATUS, '0);
      repeat (4) @(posedge clk);
      if (exp_left != 0) begin
         seq_errors++;
         $display("%0d expected stream beats never arrived", exp_left);
      end
      $display("Errors: %0d value, %0d flow, %0d sequence", value_errors, flow_errors, seq_errors);
      if (value_errors + flow_errors + seq_errors == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Timeout after %0d cycles, bus or stream stopped moving", WATCHDOG_CYCLES);
      $display("Simulation FAILED");
      $finish;
   end

endmodule

// ==== files.f ====
+incdir+logic
logic/axis_out_regs_pkg.sv
logic/axis_out_stream_pkg.sv
logic/axis_out_word_if.sv
logic/axis_out_wb_regs.sv
logic/axis_out_word_fifo.sv
logic/axis_out_serializer.sv
logic/axis_out_top.sv
sim/axis_out_checker.sv
sim/tb_axis_out.sv
